/* hdl/mm_macros.svh */
`ifndef MM_MACROS_SVH
`define MM_MACROS_SVH

// ram size in 32-bit words
`define MM_RAM_WORDS 1024

// region codes in address bits 31:28
`define MM_REGION_RAM    4'h0
`define MM_REGION_PERIPH 4'h1
`define MM_REGION_DM     4'h2

// pseudo peripheral word offsets
`define MM_PERIPH_PRINT  4'd0
`define MM_PERIPH_STATUS 4'd1
`define MM_PASS_CODE     32'd1

// debug window word offsets
`define MM_DM_CTRL    4'd0
`define MM_DM_SCRATCH 4'd1

`define MM_NDMRESET_CYCLES 4
`define MM_ERR_WORD        32'hdeadbeef

`endif

/* hdl/mm_pkg.sv */
package mm_pkg;

    // request as seen by every target
    typedef struct packed {
        logic [31:0] addr;
        logic        we;
        logic [3:0]  be;
        logic [31:0] wdata;
    } mm_req_t;

    // response back to one requester
    typedef struct packed {
        logic        gnt;
        logic        rvalid;
        logic [31:0] rdata;
    } mm_rsp_t;

    typedef struct packed {
        logic [3:0]  region;
        logic [25:0] word_idx;
        logic [1:0]  byte_off;
    } mm_ram_view_t;

    typedef struct packed {
        logic [3:0]  region;
        logic [21:0] unused;
        logic [3:0]  reg_sel;
        logic [1:0]  byte_off;
    } mm_reg_view_t;

    // memory and register targets read the same address differently
    typedef union packed {
        mm_ram_view_t ram_view;
        mm_reg_view_t reg_view;
    } mm_addr_u;

    typedef enum logic [1:0] {
        TGT_RAM,
        TGT_PERIPH,
        TGT_DM,
        TGT_NONE
    } mm_target_e;

endpackage

/* hdl/mm_ctrl.sv */
`timescale 1ns/100ps
`include "mm_macros.svh"

module mm_ctrl import mm_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  mm_req_t     data_req_i,
    input  logic        data_valid_i,
    input  mm_req_t     sb_req_i,
    input  logic        sb_valid_i,
    output mm_rsp_t     data_rsp_o,
    output mm_rsp_t     sb_rsp_o,
    output mm_req_t     tgt_req_o,
    output logic        ram_sel_o,
    output logic        periph_sel_o,
    output logic        dm_sel_o,
    input  logic        print_full_i,
    input  logic [31:0] ram_rdata_i,
    input  logic [31:0] periph_rdata_i,
    input  logic [31:0] dm_rdata_i
);

    mm_req_t    req;
    mm_addr_u   addr;
    mm_target_e tgt;
    logic       pick_sb;
    logic       req_valid;
    logic       print_blocked;
    logic       grant;
    logic       active_q;
    logic       rvalid_q;
    logic       rsp_sb_q;
    mm_target_e tgt_q;
    logic [31:0] rdata;

    // fixed priority, system bus first
    assign pick_sb   = sb_valid_i;
    assign req       = pick_sb ? sb_req_i : data_req_i;
    assign req_valid = sb_valid_i | data_valid_i;
    assign addr      = req.addr;

    always_comb begin
        case (addr.reg_view.region)
            `MM_REGION_RAM:    tgt = TGT_RAM;
            `MM_REGION_PERIPH: tgt = TGT_PERIPH;
            `MM_REGION_DM:     tgt = TGT_DM;
            default:           tgt = TGT_NONE;
        endcase
    end

    // stdout buffer still occupied, the requester waits
    assign print_blocked = (tgt == TGT_PERIPH) && req.we &&
                           (addr.reg_view.reg_sel == `MM_PERIPH_PRINT) && print_full_i;

    assign grant = active_q && req_valid && !print_blocked;

    assign tgt_req_o    = req;
    assign ram_sel_o    = grant && (tgt == TGT_RAM);
    assign periph_sel_o = grant && (tgt == TGT_PERIPH);
    assign dm_sel_o     = grant && (tgt == TGT_DM);

    // active_q holds off grants until reset is fully over
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            active_q <= 1'b0;
            rvalid_q <= 1'b0;
            rsp_sb_q <= 1'b0;
            tgt_q    <= TGT_NONE;
        end else begin
            active_q <= 1'b1;
            rvalid_q <= grant;
            if (grant) begin
                rsp_sb_q <= pick_sb;
                tgt_q    <= tgt;
            end
        end
    end

    // response data from the target granted last cycle
    always_comb begin
        case (tgt_q)
            TGT_RAM:    rdata = ram_rdata_i;
            TGT_PERIPH: rdata = periph_rdata_i;
            TGT_DM:     rdata = dm_rdata_i;
            default:    rdata = `MM_ERR_WORD;
        endcase
    end

    always_comb begin
        data_rsp_o.gnt    = grant && !pick_sb;
        data_rsp_o.rvalid = rvalid_q && !rsp_sb_q;
        data_rsp_o.rdata  = rdata;
        sb_rsp_o.gnt      = grant && pick_sb;
        sb_rsp_o.rvalid   = rvalid_q && rsp_sb_q;
        sb_rsp_o.rdata    = rdata;
    end

endmodule

/* hdl/mm_ram.sv */
`timescale 1ns/100ps
`include "mm_macros.svh"

module mm_ram import mm_pkg::*; (
    input  logic        clk_i,
    input  logic        sel_i,
    input  mm_req_t     req_i,
    output logic [31:0] rdata_o
);

    localparam int IdxW = $clog2(`MM_RAM_WORDS);

    logic [31:0]     mem [`MM_RAM_WORDS];
    mm_addr_u        addr;
    logic [IdxW-1:0] idx;
    logic [31:0]     rdata_q;

    assign addr = req_i.addr;
    // upper index bits alias onto the same words
    assign idx  = addr.ram_view.word_idx[IdxW-1:0];

    always_ff @(posedge clk_i) begin
        if (sel_i && req_i.we) begin
            for (int b = 0; b < 4; b++) begin
                if (req_i.be[b]) begin
                    mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
                end
            end
        end
    end

    // registered read, data shows up with rvalid
    always_ff @(posedge clk_i) begin
        if (sel_i && !req_i.we) begin
            rdata_q <= mem[idx];
        end
    end

    assign rdata_o = rdata_q;

endmodule

/* hdl/mm_periph.sv */
`timescale 1ns/100ps
`include "mm_macros.svh"

module mm_periph import mm_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        sel_i,
    input  mm_req_t     req_i,
    output logic [31:0] rdata_o,
    output logic        print_full_o,
    output logic [7:0]  char_o,
    output logic        char_valid_o,
    input  logic        char_ready_i,
    output logic        tests_passed_o,
    output logic        tests_failed_o
);

    mm_addr_u    addr;
    logic        print_we;
    logic        status_we;
    logic        pass_val;
    logic [7:0]  char_q;
    logic        char_valid_q;
    logic        passed_q;
    logic        failed_q;
    logic [31:0] rdata_q;

    assign addr      = req_i.addr;
    assign print_we  = sel_i && req_i.we && (addr.reg_view.reg_sel == `MM_PERIPH_PRINT);
    assign status_we = sel_i && req_i.we && (addr.reg_view.reg_sel == `MM_PERIPH_STATUS);
    assign pass_val  = (req_i.wdata == `MM_PASS_CODE);

    // the slot counts as free in the cycle its byte is taken
    assign print_full_o = char_valid_q && !char_ready_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            char_valid_q <= 1'b0;
            passed_q     <= 1'b0;
            failed_q     <= 1'b0;
        end else begin
            if (print_we) begin
                char_valid_q <= 1'b1;
            end else if (char_ready_i) begin
                char_valid_q <= 1'b0;
            end
            // flags are sticky until the next reset
            if (status_we) begin
                passed_q <= passed_q | pass_val;
                failed_q <= failed_q | !pass_val;
            end
        end
    end

    // character payload
    always_ff @(posedge clk_i) begin
        if (print_we) begin
            char_q <= req_i.wdata[7:0];
        end
    end

    // every word reads back the same status bits
    always_ff @(posedge clk_i) begin
        if (sel_i && !req_i.we) begin
            rdata_q <= {29'b0, print_full_o, failed_q, passed_q};
        end
    end

    assign rdata_o        = rdata_q;
    assign char_o         = char_q;
    assign char_valid_o   = char_valid_q;
    assign tests_passed_o = passed_q;
    assign tests_failed_o = failed_q;

endmodule

/* hdl/dm_regs.sv */
`timescale 1ns/100ps
`include "mm_macros.svh"

module dm_regs import mm_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        sel_i,
    input  mm_req_t     req_i,
    output logic [31:0] rdata_o,
    output logic        debug_req_o,
    output logic        ndmreset_o
);

    localparam int CntW = $clog2(`MM_NDMRESET_CYCLES + 1);

    mm_addr_u        addr;
    logic            ctrl_we;
    logic            scratch_we;
    logic            halt_q;
    logic [31:0]     scratch_q;
    logic [CntW-1:0] cnt_q;
    logic            ndmreset_q;
    logic            pulse_active;
    logic [31:0]     rdata_q;

    assign addr       = req_i.addr;
    assign ctrl_we    = sel_i && req_i.we && (addr.reg_view.reg_sel == `MM_DM_CTRL);
    assign scratch_we = sel_i && req_i.we && (addr.reg_view.reg_sel == `MM_DM_SCRATCH);

    assign pulse_active = (cnt_q != '0) || ndmreset_q;

    // pulse follows the counter by one cycle, so the response to the
    // ctrl write gets out before the rest of the system goes into reset
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            halt_q     <= 1'b0;
            scratch_q  <= '0;
            cnt_q      <= '0;
            ndmreset_q <= 1'b0;
        end else begin
            if (ctrl_we) begin
                halt_q <= req_i.wdata[0];
            end
            if (ctrl_we && req_i.wdata[1]) begin
                cnt_q <= CntW'(`MM_NDMRESET_CYCLES);
            end else if (cnt_q != '0) begin
                cnt_q <= cnt_q - 1'b1;
            end
            ndmreset_q <= (cnt_q != '0);
            for (int b = 0; b < 4; b++) begin
                if (scratch_we && req_i.be[b]) begin
                    scratch_q[8*b +: 8] <= req_i.wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (sel_i && !req_i.we) begin
            case (addr.reg_view.reg_sel)
                `MM_DM_CTRL:    rdata_q <= {30'b0, pulse_active, halt_q};
                `MM_DM_SCRATCH: rdata_q <= scratch_q;
                default:        rdata_q <= '0;
            endcase
        end
    end

    assign rdata_o     = rdata_q;
    assign debug_req_o = halt_q;
    assign ndmreset_o  = ndmreset_q;

endmodule

/* hdl/rst_sync.sv */
`timescale 1ns/100ps

module rst_sync (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic ndmreset_i,
    output logic rst_no
);

    logic rst_comb_n;
    logic sync_q0;
    logic sync_q1;

    // external reset or debug-module reset
    assign rst_comb_n = rst_ni && !ndmreset_i;

    // assert right away, release after two edges
    always_ff @(posedge clk_i or negedge rst_comb_n) begin
        if (!rst_comb_n) begin
            sync_q0 <= 1'b0;
            sync_q1 <= 1'b0;
        end else begin
            sync_q0 <= 1'b1;
            sync_q1 <= sync_q0;
        end
    end

    assign rst_no = sync_q1;

endmodule

/* hdl/test_env_top.sv */
`timescale 1ns/100ps

module test_env_top import mm_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  mm_req_t    data_req_i,
    input  logic       data_valid_i,
    output mm_rsp_t    data_rsp_o,
    input  mm_req_t    sb_req_i,
    input  logic       sb_valid_i,
    output mm_rsp_t    sb_rsp_o,
    output logic [7:0] char_o,
    output logic       char_valid_o,
    input  logic       char_ready_i,
    output logic       tests_passed_o,
    output logic       tests_failed_o,
    output logic       debug_req_o
);

    mm_req_t     tgt_req;
    logic        ram_sel;
    logic        periph_sel;
    logic        dm_sel;
    logic        print_full;
    logic [31:0] ram_rdata;
    logic [31:0] periph_rdata;
    logic [31:0] dm_rdata;
    logic        ndmreset;
    logic        sys_rst_n;

    mm_ctrl i_ctrl (
        .clk_i          ( clk_i        ),
        .rst_ni         ( sys_rst_n    ),
        .data_req_i     ( data_req_i   ),
        .data_valid_i   ( data_valid_i ),
        .sb_req_i       ( sb_req_i     ),
        .sb_valid_i     ( sb_valid_i   ),
        .data_rsp_o     ( data_rsp_o   ),
        .sb_rsp_o       ( sb_rsp_o     ),
        .tgt_req_o      ( tgt_req      ),
        .ram_sel_o      ( ram_sel      ),
        .periph_sel_o   ( periph_sel   ),
        .dm_sel_o       ( dm_sel       ),
        .print_full_i   ( print_full   ),
        .ram_rdata_i    ( ram_rdata    ),
        .periph_rdata_i ( periph_rdata ),
        .dm_rdata_i     ( dm_rdata     )
    );

    mm_ram i_ram (
        .clk_i   ( clk_i     ),
        .sel_i   ( ram_sel   ),
        .req_i   ( tgt_req   ),
        .rdata_o ( ram_rdata )
    );

    mm_periph i_periph (
        .clk_i          ( clk_i          ),
        .rst_ni         ( sys_rst_n      ),
        .sel_i          ( periph_sel     ),
        .req_i          ( tgt_req        ),
        .rdata_o        ( periph_rdata   ),
        .print_full_o   ( print_full     ),
        .char_o         ( char_o         ),
        .char_valid_o   ( char_valid_o   ),
        .char_ready_i   ( char_ready_i   ),
        .tests_passed_o ( tests_passed_o ),
        .tests_failed_o ( tests_failed_o )
    );

    // debug window stays on the external reset
    dm_regs i_dm_regs (
        .clk_i       ( clk_i       ),
        .rst_ni      ( rst_ni      ),
        .sel_i       ( dm_sel      ),
        .req_i       ( tgt_req     ),
        .rdata_o     ( dm_rdata    ),
        .debug_req_o ( debug_req_o ),
        .ndmreset_o  ( ndmreset    )
    );

    rst_sync i_rst_sync (
        .clk_i      ( clk_i     ),
        .rst_ni     ( rst_ni    ),
        .ndmreset_i ( ndmreset  ),
        .rst_no     ( sys_rst_n )
    );

endmodule

/* test/tb_test_env.sv */
`timescale 1ns/100ps
`include "mm_macros.svh"

module tb_test_env import mm_pkg::*; ();

    localparam int timeout_cycles = 50;
    localparam int idx_w = $clog2(`MM_RAM_WORDS);

    localparam logic [31:0] print_addr   = {`MM_REGION_PERIPH, 22'b0, `MM_PERIPH_PRINT, 2'b00};
    localparam logic [31:0] status_addr  = {`MM_REGION_PERIPH, 22'b0, `MM_PERIPH_STATUS, 2'b00};
    localparam logic [31:0] ctrl_addr    = {`MM_REGION_DM, 22'b0, `MM_DM_CTRL, 2'b00};
    localparam logic [31:0] scratch_addr = {`MM_REGION_DM, 22'b0, `MM_DM_SCRATCH, 2'b00};

    // one bus access with what it should return
    typedef struct packed {
        logic        sb;
        mm_req_t     req;
        logic        chk;
        logic [31:0] exp_rdata;
        logic [2:0]  exp_flags;
        logic        wait_rst;
    } row_t;

    logic        clk;
    logic        rst_n;
    mm_req_t     data_req;
    logic        data_valid;
    mm_rsp_t     data_rsp;
    mm_req_t     sb_req;
    logic        sb_valid;
    mm_rsp_t     sb_rsp;
    logic [7:0]  char_data;
    logic        char_valid;
    logic        char_ready;
    logic        tests_passed;
    logic        tests_failed;
    logic        debug_req;

    row_t        rows [$];
    logic [7:0]  rx_chars [$];
    logic [31:0] ram_addr [4];
    logic [31:0] rng;
    int          errors;
    int          tests;
    int          fails;

    // reference model state
    logic [31:0] shadow_ram [`MM_RAM_WORDS];
    logic [31:0] m_scratch;
    logic        m_pass;
    logic        m_fail;
    logic        m_halt;

    test_env_top i_dut (
        .clk_i          ( clk          ),
        .rst_ni         ( rst_n        ),
        .data_req_i     ( data_req     ),
        .data_valid_i   ( data_valid   ),
        .data_rsp_o     ( data_rsp     ),
        .sb_req_i       ( sb_req       ),
        .sb_valid_i     ( sb_valid     ),
        .sb_rsp_o       ( sb_rsp       ),
        .char_o         ( char_data    ),
        .char_valid_o   ( char_valid   ),
        .char_ready_i   ( char_ready   ),
        .tests_passed_o ( tests_passed ),
        .tests_failed_o ( tests_failed ),
        .debug_req_o    ( debug_req    )
    );

    always #5 clk = ~clk;

    // byte is taken at the next rising edge
    always @(negedge clk) begin
        if (char_valid && char_ready) begin
            rx_chars.push_back(char_data);
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic mm_rsp_t port_rsp(input logic sb);
        return sb ? sb_rsp : data_rsp;
    endfunction

    function automatic string port_name(input logic sb);
        return sb ? "sb_rsp_o" : "data_rsp_o";
    endfunction

    function automatic logic [31:0] shadow_word(input logic [31:0] addr);
        mm_addr_u a;
        a = addr;
        return shadow_ram[a.ram_view.word_idx[idx_w-1:0]];
    endfunction

    task automatic check_rsp(input string name, input mm_rsp_t exp, input mm_rsp_t act,
                             input logic chk_data);
        if (act.gnt !== exp.gnt || act.rvalid !== exp.rvalid ||
            (chk_data && act.rdata !== exp.rdata)) begin
            errors++;
            $display("error: %s gnt/rvalid/rdata expected %h/%h/%h, got %h/%h/%h", name,
                     exp.gnt, exp.rvalid, exp.rdata, act.gnt, act.rvalid, act.rdata);
        end
    endtask

    task automatic check_char(input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            errors++;
            $display("error: char_o expected %h, got %h", exp, act);
        end
    endtask

    // bits are passed, failed, debug request
    task automatic check_flags(input logic [2:0] exp, input logic [2:0] act);
        if (act !== exp) begin
            errors++;
            $display("error: tests_passed_o/tests_failed_o/debug_req_o expected %h, got %h",
                     exp, act);
        end
    endtask

    task automatic finish_test(input string name, input int err0);
        tests++;
        if (errors != err0) begin
            fails++;
            $display("%s: failed", name);
        end else begin
            $display("%s: ok", name);
        end
    endtask

    task automatic drive_req(input logic sb, input mm_req_t rq, input logic v);
        if (sb) begin
            sb_req   <= rq;
            sb_valid <= v;
        end else begin
            data_req   <= rq;
            data_valid <= v;
        end
    endtask

    // called at a falling edge
    task automatic wait_gnt(input logic sb, output logic ok);
        mm_rsp_t r;
        int      n;
        n = 0;
        r = port_rsp(sb);
        while (!r.gnt && n < timeout_cycles) begin
            @(negedge clk);
            n++;
            r = port_rsp(sb);
        end
        ok = r.gnt;
        if (!ok) begin
            errors++;
            $display("timeout: no grant on the %s port after %0d cycles", sb ? "sb" : "data", n);
        end
    endtask

    // called at the rising edge that ends the grant cycle
    task automatic wait_rvalid(input logic sb);
        mm_rsp_t r;
        int      lat;
        lat = 1;
        @(negedge clk);
        r = port_rsp(sb);
        while (!r.rvalid && lat < timeout_cycles) begin
            @(negedge clk);
            lat++;
            r = port_rsp(sb);
        end
        if (!r.rvalid) begin
            errors++;
            $display("timeout: no rvalid on the %s port after the grant", sb ? "sb" : "data");
        end else if (lat != 1) begin
            errors++;
            $display("rvalid on the %s port came %0d cycles after gnt instead of 1",
                     sb ? "sb" : "data", lat);
        end
    endtask

    task automatic do_access(input logic sb, input mm_req_t rq, output mm_rsp_t rsp);
        logic ok;
        @(posedge clk);
        drive_req(sb, rq, 1'b1);
        @(negedge clk);
        wait_gnt(sb, ok);
        @(posedge clk);
        drive_req(sb, rq, 1'b0);
        rsp = '0;
        if (ok) begin
            wait_rvalid(sb);
            rsp = port_rsp(sb);
        end
    endtask

    task automatic add_row(input logic sb, input logic [31:0] addr, input logic we,
                           input logic [3:0] be, input logic [31:0] wdata);
        row_t     r;
        mm_addr_u a;
        int       b;
        a = addr;
        r = '0;
        r.sb = sb;
        r.req.addr = addr;
        r.req.we = we;
        r.req.be = be;
        r.req.wdata = wdata;
        r.chk = !we;
        case (a.reg_view.region)
            `MM_REGION_RAM: begin
                for (b = 0; b < 4; b++) begin
                    if (we && be[b]) begin
                        shadow_ram[a.ram_view.word_idx[idx_w-1:0]][8*b +: 8] = wdata[8*b +: 8];
                    end
                end
                r.exp_rdata = shadow_word(addr);
            end
            `MM_REGION_PERIPH: begin
                if (we && a.reg_view.reg_sel == `MM_PERIPH_STATUS) begin
                    if (wdata == `MM_PASS_CODE) begin
                        m_pass = 1'b1;
                    end else begin
                        m_fail = 1'b1;
                    end
                end
                // stdout buffer is drained by the time the table runs
                r.exp_rdata = {30'b0, m_fail, m_pass};
            end
            `MM_REGION_DM: begin
                if (a.reg_view.reg_sel == `MM_DM_CTRL) begin
                    if (we) begin
                        m_halt = wdata[0];
                        if (wdata[1]) begin
                            r.wait_rst = 1'b1;
                            m_pass = 1'b0;
                            m_fail = 1'b0;
                        end
                    end
                    r.exp_rdata = {31'b0, m_halt};
                end else begin
                    for (b = 0; b < 4; b++) begin
                        if (we && be[b]) begin
                            m_scratch[8*b +: 8] = wdata[8*b +: 8];
                        end
                    end
                    r.exp_rdata = m_scratch;
                end
            end
            default: r.exp_rdata = `MM_ERR_WORD;
        endcase
        r.exp_flags = {m_pass, m_fail, m_halt};
        rows.push_back(r);
    endtask

    task automatic build_table();
        logic [31:0] rnd;
        int          k;
        // distinct words, full write first so partial writes land on known data
        for (k = 0; k < 4; k++) begin
            rnd = next_rand();
            ram_addr[k] = {`MM_REGION_RAM, 16'b0, rnd[9:3], k[2:0], 2'b00};
            add_row(k[0], ram_addr[k], 1'b1, 4'hf, next_rand());
            rnd = next_rand();
            add_row(!k[0], ram_addr[k], 1'b1, rnd[3:0], next_rand());
            add_row(1'b1, ram_addr[k], 1'b0, 4'hf, '0);
            add_row(1'b0, ram_addr[k], 1'b0, 4'hf, '0);
        end
        rnd = next_rand();
        add_row(1'b1, {4'h7, rnd[27:0]}, 1'b0, 4'hf, '0);
        add_row(1'b0, {4'hc, rnd[31:4]}, 1'b0, 4'hf, '0);
        add_row(1'b0, {4'h5, rnd[27:0]}, 1'b1, 4'hf, rnd);
        add_row(1'b0, scratch_addr, 1'b1, 4'hf, next_rand());
        add_row(1'b1, scratch_addr, 1'b1, 4'b0101, next_rand());
        add_row(1'b1, scratch_addr, 1'b0, 4'hf, '0);
        add_row(1'b1, ctrl_addr, 1'b1, 4'hf, 32'h1);
        add_row(1'b0, ctrl_addr, 1'b0, 4'hf, '0);
        add_row(1'b0, status_addr, 1'b1, 4'hf, `MM_PASS_CODE);
        add_row(1'b1, status_addr, 1'b1, 4'hf, next_rand() | 32'h2);
        add_row(1'b0, status_addr, 1'b0, 4'hf, '0);
        // halt stays set while ndmreset fires
        add_row(1'b1, ctrl_addr, 1'b1, 4'hf, 32'h3);
        for (k = 0; k < 4; k++) begin
            add_row(k[0], ram_addr[k], 1'b0, 4'hf, '0);
        end
        add_row(1'b0, scratch_addr, 1'b0, 4'hf, '0);
        add_row(1'b1, ctrl_addr, 1'b0, 4'hf, '0);
    endtask

    task automatic wait_flags_clear();
        int n;
        n = 0;
        while ((tests_passed || tests_failed) && n < timeout_cycles) begin
            @(negedge clk);
            n++;
        end
        if (tests_passed || tests_failed) begin
            errors++;
            $display("timeout: ndmreset did not clear the passed and failed flags");
        end
    endtask

    task automatic print_test();
        mm_req_t     rq;
        mm_rsp_t     rsp;
        mm_rsp_t     exp;
        logic [31:0] rnd;
        logic [7:0]  sent [3];
        int          i;
        int          n;
        exp = {1'b0, 1'b1, 32'h0};
        rq = '0;
        rq.addr = print_addr;
        rq.we = 1'b1;
        rq.be = 4'h1;
        rnd = next_rand();
        sent[0] = rnd[7:0];
        rq.wdata = rnd;
        do_access(1'b0, rq, rsp);
        check_rsp("data_rsp_o", exp, rsp, 1'b0);
        rnd = next_rand();
        sent[1] = rnd[7:0];
        rq.wdata = rnd;
        fork
            do_access(1'b0, rq, rsp);
            begin
                repeat (4) begin
                    @(negedge clk);
                    if (data_rsp.gnt) begin
                        errors++;
                        $display("print write was granted while the stdout buffer was full");
                    end
                end
                @(posedge clk);
                char_ready <= 1'b1;
            end
        join
        check_rsp("data_rsp_o", exp, rsp, 1'b0);
        rnd = next_rand();
        sent[2] = rnd[7:0];
        rq.wdata = rnd;
        do_access(1'b0, rq, rsp);
        check_rsp("data_rsp_o", exp, rsp, 1'b0);
        n = 0;
        while (rx_chars.size() < 3 && n < timeout_cycles) begin
            @(negedge clk);
            n++;
        end
        if (rx_chars.size() != 3) begin
            errors++;
            $display("expected 3 bytes on char_o, %0d arrived", rx_chars.size());
        end
        for (i = 0; i < 3 && i < rx_chars.size(); i++) begin
            check_char(sent[i], rx_chars[i]);
        end
    endtask

    task automatic priority_test(input mm_req_t sb_rq, input mm_req_t d_rq);
        mm_rsp_t exp;
        mm_rsp_t got;
        logic    ok;
        @(posedge clk);
        drive_req(1'b1, sb_rq, 1'b1);
        drive_req(1'b0, d_rq, 1'b1);
        @(negedge clk);
        wait_gnt(1'b1, ok);
        if (data_rsp.gnt) begin
            errors++;
            $display("data port was granted in the same cycle as the sb port");
        end
        @(posedge clk);
        drive_req(1'b1, sb_rq, 1'b0);
        @(negedge clk);
        got = sb_rsp;
        exp = {1'b0, 1'b1, shadow_word(sb_rq.addr)};
        check_rsp("sb_rsp_o", exp, got, 1'b1);
        // data port follows back to back
        wait_gnt(1'b0, ok);
        @(posedge clk);
        drive_req(1'b0, d_rq, 1'b0);
        if (ok) begin
            wait_rvalid(1'b0);
            exp = {1'b0, 1'b1, shadow_word(d_rq.addr)};
            check_rsp("data_rsp_o", exp, data_rsp, 1'b1);
        end
    endtask

    initial begin
        mm_rsp_t rsp;
        mm_rsp_t exp;
        mm_req_t sq;
        mm_req_t dq;
        int      err0;
        int      i;
        clk = 1'b0;
        rst_n = 1'b0;
        data_req = '0;
        data_valid = 1'b0;
        sb_req = '0;
        sb_valid = 1'b0;
        char_ready = 1'b0;
        rng = 32'h6afd;
        errors = 0;
        tests = 0;
        fails = 0;
        m_scratch = '0;
        m_pass = 1'b0;
        m_fail = 1'b0;
        m_halt = 1'b0;
        build_table();
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        err0 = errors;
        print_test();
        finish_test("stdout back-pressure", err0);

        for (i = 0; i < rows.size(); i++) begin
            err0 = errors;
            do_access(rows[i].sb, rows[i].req, rsp);
            exp = {1'b0, 1'b1, rows[i].exp_rdata};
            check_rsp(port_name(rows[i].sb), exp, rsp, rows[i].chk);
            if (rows[i].wait_rst) begin
                wait_flags_clear();
            end
            check_flags(rows[i].exp_flags, {tests_passed, tests_failed, debug_req});
            finish_test($sformatf("row %0d", i), err0);
        end

        sq = '0;
        sq.addr = ram_addr[0];
        sq.be = 4'hf;
        dq = sq;
        dq.addr = ram_addr[1];
        err0 = errors;
        priority_test(sq, dq);
        finish_test("port priority", err0);

        $display("%0d tests run, %0d failed, %0d errors", tests, fails, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+hdl
hdl/mm_pkg.sv
hdl/mm_ctrl.sv
hdl/mm_ram.sv
hdl/mm_periph.sv
hdl/dm_regs.sv
hdl/rst_sync.sv
hdl/test_env_top.sv
test/tb_test_env.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_test_env -f project.f -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
